// ==== hdl/gpio_pkg.sv ====
// GPIO shared definitions

package gpio_pkg;

  ////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////

  localparam int wb_data_w_c = 32;
  localparam int wb_sel_w_c  = wb_data_w_c / 8;
  localparam int wb_addr_w_c = 5;
  localparam int reg_idx_w_c = 3;

  typedef logic [wb_data_w_c-1:0] wb_data_t;
  typedef logic [wb_sel_w_c-1:0]  wb_sel_t;
  typedef logic [wb_addr_w_c-1:0] wb_addr_t;
  typedef logic [reg_idx_w_c-1:0] reg_idx_t;

  ////////////////////////////////////////////////////////////
  // Register map, word index from address bits 4 to 2
  ////////////////////////////////////////////////////////////

  localparam reg_idx_t reg_in_c    = 3'd0;
  localparam reg_idx_t reg_out_c   = 3'd1;
  localparam reg_idx_t reg_dir_c   = 3'd2;
  localparam reg_idx_t reg_iosel_c = 3'd3;
  localparam reg_idx_t reg_ie_c    = 3'd4;
  localparam reg_idx_t reg_is_c    = 3'd5;
  // Last mapped index, anything above is a bus error
  localparam reg_idx_t reg_trig_c  = 3'd6;

  // Wishbone slave states
  typedef enum logic {
    wb_idle_s,
    wb_resp_s
  } wb_state_e;

  // Expand byte selects into a bit mask
  function automatic wb_data_t lane_mask(input wb_sel_t sel);
    wb_data_t mask;
    for (int i = 0; i < wb_sel_w_c; i++) begin
      mask[i*8 +: 8] = {8{sel[i]}};
    end
    return mask;
  endfunction

endpackage

// ==== hdl/gpio_reg_bus_if.sv ====
// GPIO register access bus
`timescale 1ns/1ps

interface gpio_reg_bus_if;
  import gpio_pkg::*;

  // One-cycle write strobe
  logic     wr;
  // Decoded register index, held continuously
  reg_idx_t idx;
  wb_sel_t  sel;
  wb_data_t wdata;
  // Readback for the current index
  wb_data_t rdata;

  modport master (
    output wr,
    output idx,
    output sel,
    output wdata,
    input  rdata
  );

  modport regs (
    input  wr,
    input  idx,
    input  sel,
    input  wdata,
    output rdata
  );

  // Interrupt controller only listens
  modport irq (
    input wr,
    input idx,
    input sel,
    input wdata
  );

endinterface

// ==== hdl/gpio_wb_slave.sv ====
// Wishbone classic slave
`timescale 1ns/1ps

module gpio_wb_slave (
  input  logic               wb_clk_i,
  input  logic               wb_rst_i,
  input  logic               wb_cyc_i,
  input  logic               wb_stb_i,
  input  logic               wb_we_i,
  input  gpio_pkg::wb_addr_t wb_adr_i,
  input  gpio_pkg::wb_data_t wb_dat_i,
  input  gpio_pkg::wb_sel_t  wb_sel_i,
  output gpio_pkg::wb_data_t wb_dat_o,
  output logic               wb_ack_o,
  output logic               wb_err_o,
  gpio_reg_bus_if.master     bus_o
);
  import gpio_pkg::*;

  wb_state_e state_q;
  logic      access;
  logic      bad_idx;

  ////////////////////////////////////////////////////////////
  // Decode
  ////////////////////////////////////////////////////////////

  // New request only accepted from idle
  assign access  = wb_cyc_i && wb_stb_i && (state_q == wb_idle_s);
  assign bad_idx = (bus_o.idx > reg_trig_c);

  assign bus_o.idx   = wb_adr_i[4:2];
  assign bus_o.sel   = wb_sel_i;
  assign bus_o.wdata = wb_dat_i;
  // Commit happens on the same edge that enters resp
  assign bus_o.wr    = access && wb_we_i && !bad_idx;

  ////////////////////////////////////////////////////////////
  // Response FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      state_q  <= wb_idle_s;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      case (state_q)
        wb_idle_s: begin
          if (access) begin
            state_q  <= wb_resp_s;
            wb_ack_o <= !bad_idx;
            wb_err_o <= bad_idx;
          end
        end
        default: begin
          state_q  <= wb_idle_s;
          wb_ack_o <= 1'b0;
          wb_err_o <= 1'b0;
        end
      endcase
    end
  end

  // Read data held for the response cycle
  always_ff @(posedge wb_clk_i) begin
    if (access) begin
      wb_dat_o <= bus_o.rdata;
    end
  end

  ack_err_excl_a: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) !(wb_ack_o && wb_err_o)
  );

  // Single-cycle response, never back to back
  resp_single_a: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o)
  );

endmodule

// ==== hdl/gpio_regfile.sv ====
// GPIO register file
`timescale 1ns/1ps

module gpio_regfile #(
  parameter int num_pins_p   = 32,
  parameter int num_shared_p = 15
) (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  logic [num_pins_p-1:0]   pins_in_i,
  input  logic [num_pins_p-1:0]   status_i,
  gpio_reg_bus_if.regs            bus_i,
  output logic [num_pins_p-1:0]   out_o,
  output logic [num_pins_p-1:0]   dir_o,
  output logic [num_shared_p-1:0] iosel_o,
  output logic [num_pins_p-1:0]   ie_o,
  output logic [num_pins_p-1:0]   trig_o
);
  import gpio_pkg::*;

  wb_data_t                lane_m;
  logic [num_pins_p-1:0]   pin_mask;
  logic [num_pins_p-1:0]   pin_wdata;
  logic [num_shared_p-1:0] sh_mask;
  logic [num_shared_p-1:0] sh_wdata;
  logic                    wr_out;
  logic                    wr_dir;
  logic                    wr_iosel;
  logic                    wr_ie;
  logic                    wr_trig;

  ////////////////////////////////////////////////////////////
  // Write side
  ////////////////////////////////////////////////////////////

  // Only the implemented bits of each lane take part
  assign lane_m    = lane_mask(bus_i.sel);
  assign pin_mask  = lane_m[num_pins_p-1:0];
  assign pin_wdata = bus_i.wdata[num_pins_p-1:0];
  assign sh_mask   = lane_m[num_shared_p-1:0];
  assign sh_wdata  = bus_i.wdata[num_shared_p-1:0];

  assign wr_out   = bus_i.wr && (bus_i.idx == reg_out_c);
  assign wr_dir   = bus_i.wr && (bus_i.idx == reg_dir_c);
  assign wr_iosel = bus_i.wr && (bus_i.idx == reg_iosel_c);
  assign wr_ie    = bus_i.wr && (bus_i.idx == reg_ie_c);
  assign wr_trig  = bus_i.wr && (bus_i.idx == reg_trig_c);

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      out_o   <= '0;
      // Every pin starts as an input
      dir_o   <= '1;
      iosel_o <= '0;
      ie_o    <= '0;
      trig_o  <= '0;
    end else begin
      if (wr_out) begin
        out_o <= (out_o & ~pin_mask) | (pin_wdata & pin_mask);
      end
      if (wr_dir) begin
        dir_o <= (dir_o & ~pin_mask) | (pin_wdata & pin_mask);
      end
      if (wr_iosel) begin
        iosel_o <= (iosel_o & ~sh_mask) | (sh_wdata & sh_mask);
      end
      if (wr_ie) begin
        ie_o <= (ie_o & ~pin_mask) | (pin_wdata & pin_mask);
      end
      if (wr_trig) begin
        trig_o <= (trig_o & ~pin_mask) | (pin_wdata & pin_mask);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Readback mux
  ////////////////////////////////////////////////////////////

  always_comb begin
    // Unused upper bits and index 7 read as zero
    bus_i.rdata = '0;
    case (bus_i.idx)
      reg_in_c:    bus_i.rdata[num_pins_p-1:0]   = pins_in_i;
      reg_out_c:   bus_i.rdata[num_pins_p-1:0]   = out_o;
      reg_dir_c:   bus_i.rdata[num_pins_p-1:0]   = dir_o;
      reg_iosel_c: bus_i.rdata[num_shared_p-1:0] = iosel_o;
      reg_ie_c:    bus_i.rdata[num_pins_p-1:0]   = ie_o;
      reg_is_c:    bus_i.rdata[num_pins_p-1:0]   = status_i;
      reg_trig_c:  bus_i.rdata[num_pins_p-1:0]   = trig_o;
      default:     bus_i.rdata = '0;
    endcase
  end

  // No write can land before the first edge out of reset
  dir_reset_a: assert property (
    @(posedge wb_clk_i) $fell(wb_rst_i) |-> (dir_o == {num_pins_p{1'b1}})
  );

endmodule

// ==== hdl/gpio_input_sync.sv ====
// GPIO input synchronizer and edge detect
`timescale 1ns/1ps

module gpio_input_sync #(
  parameter int num_pins_p = 32
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic [num_pins_p-1:0] gpio_i,
  output logic [num_pins_p-1:0] sync_o,
  output logic [num_pins_p-1:0] rise_o,
  output logic [num_pins_p-1:0] fall_o
);

  logic [num_pins_p-1:0] meta_q;
  logic [num_pins_p-1:0] sync_q;
  // Previous synchronized value
  logic [num_pins_p-1:0] prev_q;

  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      meta_q <= '0;
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      meta_q <= gpio_i;
      sync_q <= meta_q;
      prev_q <= sync_q;
    end
  end

  assign sync_o = sync_q;
  assign rise_o = sync_q & ~prev_q;
  assign fall_o = ~sync_q & prev_q;

  rise_fall_excl_a: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i) (rise_o & fall_o) == '0
  );

endmodule

// ==== hdl/gpio_irq_ctrl.sv ====
// GPIO interrupt controller
`timescale 1ns/1ps

module gpio_irq_ctrl #(
  parameter int num_pins_p = 32
) (
  input  logic                  wb_clk_i,
  input  logic                  wb_rst_i,
  input  logic [num_pins_p-1:0] rise_i,
  input  logic [num_pins_p-1:0] fall_i,
  input  logic [num_pins_p-1:0] dir_i,
  input  logic [num_pins_p-1:0] ie_i,
  input  logic [num_pins_p-1:0] trig_i,
  gpio_reg_bus_if.irq           bus_i,
  output logic [num_pins_p-1:0] status_o,
  output logic                  wb_inta_o
);
  import gpio_pkg::*;

  wb_data_t              clr_word;
  logic [num_pins_p-1:0] clr_bits;
  logic [num_pins_p-1:0] edge_sel;
  logic [num_pins_p-1:0] edge_qual;

  ////////////////////////////////////////////////////////////
  // Edge selection
  ////////////////////////////////////////////////////////////

  // Trigger bit 1 picks rising, 0 picks falling
  assign edge_sel  = (trig_i & rise_i) | (~trig_i & fall_i);
  // Only enabled pins configured as inputs count
  assign edge_qual = edge_sel & dir_i & ie_i;

  ////////////////////////////////////////////////////////////
  // Status register
  ////////////////////////////////////////////////////////////

  always_comb begin
    clr_word = '0;
    if (bus_i.wr && (bus_i.idx == reg_is_c)) begin
      clr_word = bus_i.wdata & lane_mask(bus_i.sel);
    end
  end

  assign clr_bits = clr_word[num_pins_p-1:0];

  // Clear beats a same-cycle edge on the bits being cleared
  always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
    if (wb_rst_i) begin
      status_o <= '0;
    end else begin
      status_o <= (status_o | edge_qual) & ~clr_bits;
    end
  end

  assign wb_inta_o = |(status_o & ie_i);

endmodule

// ==== hdl/gpio_top.sv ====
// GPIO with edge interrupts
`timescale 1ns/1ps

module gpio_top #(
  parameter int num_pins_p   = 32,
  parameter int num_shared_p = 15
) (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  logic                    wb_cyc_i,
  input  logic                    wb_stb_i,
  input  logic                    wb_we_i,
  input  gpio_pkg::wb_addr_t      wb_adr_i,
  input  gpio_pkg::wb_data_t      wb_dat_i,
  input  gpio_pkg::wb_sel_t       wb_sel_i,
  output gpio_pkg::wb_data_t      wb_dat_o,
  output logic                    wb_ack_o,
  output logic                    wb_err_o,
  output logic                    wb_inta_o,
  // Pin side
  input  logic [num_pins_p-1:0]   gpio_i,
  output logic [num_pins_p-1:0]   gpio_o,
  output logic [num_pins_p-1:0]   en_gpio_o,
  output logic [num_shared_p-1:0] io_sel_o
);

  logic [num_pins_p-1:0] pin_sync;
  logic [num_pins_p-1:0] pin_rise;
  logic [num_pins_p-1:0] pin_fall;
  logic [num_pins_p-1:0] irq_en;
  logic [num_pins_p-1:0] irq_trig;
  logic [num_pins_p-1:0] irq_status;

  gpio_reg_bus_if reg_bus ();

  gpio_wb_slave u_slave (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_sel_i (wb_sel_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .wb_err_o (wb_err_o),
    .bus_o    (reg_bus.master)
  );

  gpio_regfile #(
    .num_pins_p   (num_pins_p),
    .num_shared_p (num_shared_p)
  ) u_regfile (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .pins_in_i (pin_sync),
    .status_i  (irq_status),
    .bus_i     (reg_bus.regs),
    .out_o     (gpio_o),
    .dir_o     (en_gpio_o),
    .iosel_o   (io_sel_o),
    .ie_o      (irq_en),
    .trig_o    (irq_trig)
  );

  gpio_input_sync #(
    .num_pins_p (num_pins_p)
  ) u_sync (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .gpio_i   (gpio_i),
    .sync_o   (pin_sync),
    .rise_o   (pin_rise),
    .fall_o   (pin_fall)
  );

  // Direction register doubles as the input qualifier
  gpio_irq_ctrl #(
    .num_pins_p (num_pins_p)
  ) u_irq (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .rise_i    (pin_rise),
    .fall_i    (pin_fall),
    .dir_i     (en_gpio_o),
    .ie_i      (irq_en),
    .trig_i    (irq_trig),
    .bus_i     (reg_bus.irq),
    .status_o  (irq_status),
    .wb_inta_o (wb_inta_o)
  );

endmodule

// ==== tb/gpio_checker.sv ====
// GPIO response checker
`timescale 1ns/1ps

module gpio_checker (
  input  logic            wb_clk_i,
  input  logic            wb_ack_i,
  input  logic            wb_err_i,
  input  logic [31:0]     wb_dat_i,
  input  logic            wb_inta_i,
  input  logic [31:0]     gpio_i,
  input  logic [31:0]     en_gpio_i,
  input  logic [14:0]     io_sel_i,
  input  logic            exp_rd_i,
  input  logic            exp_err_i,
  input  logic [31:0]     exp_data_i,
  input  logic            pin_chk_i,
  input  logic [31:0]     exp_out_i,
  input  logic [31:0]     exp_dir_i,
  input  logic [14:0]     exp_iosel_i,
  input  logic            exp_inta_i,
  input  logic [8*12-1:0] name_i,
  output int              errors_o,
  output int              checks_o
);

  int errors = 0;
  int checks = 0;

  assign errors_o = errors;
  assign checks_o = checks;

  task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("error %0s %0s: expected %h actual %h", name_i, what, exp, act);
    end
  endtask

  // Sampled before the registered outputs update on this edge
  always @(posedge wb_clk_i) begin
    if (wb_ack_i || wb_err_i) begin
      // Exactly one of ack and err answers an access
      compare("wb_ack_o", {31'b0, ~exp_err_i}, {31'b0, wb_ack_i});
      compare("wb_err_o", {31'b0, exp_err_i}, {31'b0, wb_err_i});
      if (exp_rd_i && wb_ack_i) begin
        compare("wb_dat_o", exp_data_i, wb_dat_i);
      end
    end
    if (pin_chk_i) begin
      compare("gpio_o", exp_out_i, gpio_i);
      compare("en_gpio_o", exp_dir_i, en_gpio_i);
      compare("io_sel_o", {17'b0, exp_iosel_i}, {17'b0, io_sel_i});
      compare("wb_inta_o", {31'b0, exp_inta_i}, {31'b0, wb_inta_i});
    end
  end

endmodule

// ==== tb/gpio_tb.sv ====
// GPIO testbench
`timescale 1ns/1ps

module gpio_tb;

  // Step operations
  localparam logic [2:0] op_rd_c  = 3'd0;
  localparam logic [2:0] op_wr_c  = 3'd1;
  localparam logic [2:0] op_wrr_c = 3'd2;
  localparam logic [2:0] op_all_c = 3'd3;
  localparam logic [2:0] op_pin_c = 3'd4;
  localparam logic [2:0] op_err_c = 3'd5;
  localparam logic [31:0] shared_mask_c = 32'h0000_7fff;

  typedef struct packed {
    logic [2:0]      op;
    logic [4:0]      addr;
    logic [31:0]     data;
    logic [3:0]      sel;
    logic [31:0]     exp;
    logic [8*12-1:0] name;
  } step_t;

  logic        wb_clk_i = 1'b0;
  logic        wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i;
  logic [4:0]  wb_adr_i;
  logic [31:0] wb_dat_i, wb_dat_o;
  logic [3:0]  wb_sel_i;
  logic        wb_ack_o, wb_err_o, wb_inta_o;
  logic [31:0] gpio_i, gpio_o, en_gpio_o;
  logic [14:0] io_sel_o;

  // Expected values for the checker
  logic            exp_rd, exp_err, pin_chk, exp_inta;
  logic [31:0]     exp_data, exp_out, exp_dir;
  logic [14:0]     exp_iosel;
  logic [8*12-1:0] cur_name;
  int              errors, checks;

  step_t       steps [0:63];
  int          n_steps = 0;
  int          limit = 0;
  int          cycles = 0;
  logic [31:0] model [0:7];
  logic [31:0] lcg_state = 32'd37;

  gpio_top #(.num_pins_p(32), .num_shared_p(15)) dut0 (.*);

  gpio_checker chk0 (
    .wb_clk_i    (wb_clk_i),
    .wb_ack_i    (wb_ack_o),
    .wb_err_i    (wb_err_o),
    .wb_dat_i    (wb_dat_o),
    .wb_inta_i   (wb_inta_o),
    .gpio_i      (gpio_o),
    .en_gpio_i   (en_gpio_o),
    .io_sel_i    (io_sel_o),
    .exp_rd_i    (exp_rd),
    .exp_err_i   (exp_err),
    .exp_data_i  (exp_data),
    .pin_chk_i   (pin_chk),
    .exp_out_i   (exp_out),
    .exp_dir_i   (exp_dir),
    .exp_iosel_i (exp_iosel),
    .exp_inta_i  (exp_inta),
    .name_i      (cur_name),
    .errors_o    (errors),
    .checks_o    (checks)
  );

  always #5 wb_clk_i = ~wb_clk_i;

  always @(posedge wb_clk_i) begin
    cycles++;
    if (cycles > limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Random numbers and the register model
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Upper halves only, the low LCG bits repeat quickly
  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi[31:16], lo[31:16]};
  endfunction

  function automatic logic [31:0] byte_mask(input logic [3:0] sel);
    return {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
  endfunction

  task automatic model_write(input logic [4:0] adr, input logic [31:0] data,
                             input logic [3:0] sel);
    logic [31:0] m;
    logic [2:0]  idx;
    m   = byte_mask(sel);
    idx = adr[4:2];
    case (idx)
      3'd1, 3'd2, 3'd4, 3'd6: model[idx] = (model[idx] & ~m) | (data & m);
      3'd3:    model[3] = ((model[3] & ~m) | (data & m)) & shared_mask_c;
      3'd5:    model[5] = model[5] & ~(data & m);
      default: ;
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Bus and pin tasks
  ////////////////////////////////////////////////////////////

  task automatic wb_access(input logic we, input logic [4:0] adr, input logic [31:0] data,
                           input logic [3:0] sel, input logic [31:0] exp,
                           input logic want_err);
    @(negedge wb_clk_i);
    exp_rd   = !we;
    exp_err  = want_err;
    exp_data = exp;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = data;
    wb_sel_i = sel;
    @(negedge wb_clk_i);
    while (!(wb_ack_o || wb_err_o)) begin
      @(negedge wb_clk_i);
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic check_all();
    for (int i = 0; i < 7; i++) begin
      wb_access(1'b0, {i[2:0], 2'b00}, 32'h0, 4'hf, model[i], 1'b0);
    end
    @(negedge wb_clk_i);
    exp_out   = model[1];
    exp_dir   = model[2];
    exp_iosel = model[3][14:0];
    exp_inta  = |(model[5] & model[4]);
    pin_chk   = 1'b1;
    @(negedge wb_clk_i);
    pin_chk   = 1'b0;
  endtask

  // Edge picked by trigger, qualified by direction and enable
  task automatic drive_pins(input logic [31:0] mask);
    logic [31:0] pins_new;
    logic [31:0] rise;
    logic [31:0] fall;
    pins_new = (gpio_i & ~mask) | (rand_word() & mask);
    rise     = pins_new & ~gpio_i;
    fall     = ~pins_new & gpio_i;
    model[5] = model[5] | (((model[6] & rise) | (~model[6] & fall)) & model[2] & model[4]);
    model[0] = pins_new;
    @(negedge wb_clk_i);
    gpio_i = pins_new;
    repeat (5) @(negedge wb_clk_i);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] data;
    @(negedge wb_clk_i);
    cur_name = s.name;
    case (s.op)
      op_rd_c: wb_access(1'b0, s.addr, 32'h0, 4'hf, s.exp, 1'b0);
      op_wr_c: begin
        wb_access(1'b1, s.addr, s.data, s.sel, 32'h0, 1'b0);
        model_write(s.addr, s.data, s.sel);
      end
      op_wrr_c: begin
        data = rand_word();
        wb_access(1'b1, s.addr, data, s.sel, 32'h0, 1'b0);
        model_write(s.addr, data, s.sel);
        check_all();
      end
      op_all_c: check_all();
      op_pin_c: begin
        drive_pins(s.data);
        check_all();
      end
      default: begin
        wb_access(1'b1, s.addr, s.data, s.sel, 32'h0, 1'b1);
        wb_access(1'b0, s.addr, 32'h0, 4'hf, 32'h0, 1'b1);
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic add_row(input logic [2:0] op, input logic [4:0] addr, input logic [31:0] data,
                         input logic [3:0] sel, input logic [31:0] exp,
                         input logic [8*12-1:0] name);
    steps[n_steps] = {op, addr, data, sel, exp, name};
    n_steps++;
  endtask

  task automatic load_table();
    add_row(op_rd_c,  5'h04, 32'h0, 4'h0, 32'h0000_0000, "rst_out");
    add_row(op_rd_c,  5'h08, 32'h0, 4'h0, 32'hffff_ffff, "rst_dir");
    add_row(op_rd_c,  5'h0c, 32'h0, 4'h0, 32'h0000_0000, "rst_iosel");
    add_row(op_rd_c,  5'h10, 32'h0, 4'h0, 32'h0000_0000, "rst_ie");
    add_row(op_rd_c,  5'h14, 32'h0, 4'h0, 32'h0000_0000, "rst_is");
    add_row(op_rd_c,  5'h18, 32'h0, 4'h0, 32'h0000_0000, "rst_trig");
    add_row(op_all_c, 5'h00, 32'h0, 4'h0, 32'h0, "rst_pins");
    add_row(op_wrr_c, 5'h04, 32'h0, 4'hf, 32'h0, "lane_out_f");
    add_row(op_wrr_c, 5'h04, 32'h0, 4'h6, 32'h0, "lane_out_6");
    add_row(op_wrr_c, 5'h04, 32'h0, 4'h8, 32'h0, "lane_out_8");
    add_row(op_wrr_c, 5'h08, 32'h0, 4'hf, 32'h0, "lane_dir_f");
    add_row(op_wrr_c, 5'h08, 32'h0, 4'h3, 32'h0, "lane_dir_3");
    add_row(op_wrr_c, 5'h10, 32'h0, 4'ha, 32'h0, "lane_ie_a");
    add_row(op_wrr_c, 5'h10, 32'h0, 4'h5, 32'h0, "lane_ie_5");
    add_row(op_wrr_c, 5'h18, 32'h0, 4'hc, 32'h0, "lane_trig_c");
    add_row(op_wrr_c, 5'h18, 32'h0, 4'h1, 32'h0, "lane_trig_1");
    add_row(op_wrr_c, 5'h0c, 32'h0, 4'hf, 32'h0, "lane_iosel_f");
    add_row(op_wrr_c, 5'h0c, 32'h0, 4'h6, 32'h0, "lane_iosel_6");
    add_row(op_pin_c, 5'h00, 32'hffff_ffff, 4'h0, 32'h0, "pins_in_0");
    add_row(op_pin_c, 5'h00, 32'hffff_ffff, 4'h0, 32'h0, "pins_in_1");
    add_row(op_wr_c,  5'h08, 32'hffff_00ff, 4'hf, 32'h0, "cfg_dir");
    add_row(op_wr_c,  5'h10, 32'h0f0f_f0f0, 4'hf, 32'h0, "cfg_ie");
    add_row(op_wr_c,  5'h18, 32'h3c3c_3c3c, 4'hf, 32'h0, "cfg_trig");
    add_row(op_wr_c,  5'h14, 32'hffff_ffff, 4'hf, 32'h0, "cfg_clr");
    add_row(op_pin_c, 5'h00, 32'hffff_ffff, 4'h0, 32'h0, "edge_0");
    add_row(op_pin_c, 5'h00, 32'h0000_ffff, 4'h0, 32'h0, "edge_1");
    add_row(op_pin_c, 5'h00, 32'hffff_0000, 4'h0, 32'h0, "edge_2");
    add_row(op_pin_c, 5'h00, 32'hffff_ffff, 4'h0, 32'h0, "edge_3");
    add_row(op_wr_c,  5'h14, 32'h00ff_ff00, 4'h2, 32'h0, "w1c_lane1");
    add_row(op_all_c, 5'h00, 32'h0, 4'h0, 32'h0, "w1c_lane1");
    add_row(op_wr_c,  5'h14, 32'h5a5a_5a5a, 4'h5, 32'h0, "w1c_lane02");
    add_row(op_all_c, 5'h00, 32'h0, 4'h0, 32'h0, "w1c_lane02");
    add_row(op_wr_c,  5'h14, 32'hffff_ffff, 4'hf, 32'h0, "w1c_all");
    add_row(op_all_c, 5'h00, 32'h0, 4'h0, 32'h0, "w1c_all");
    add_row(op_err_c, 5'h1c, 32'hffff_ffff, 4'hf, 32'h0, "bus_err");
    add_row(op_all_c, 5'h00, 32'h0, 4'h0, 32'h0, "bus_err");
  endtask

  initial begin
    wb_rst_i  = 1'b1;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    wb_sel_i  = '0;
    gpio_i    = '0;
    exp_rd    = 1'b0;
    exp_err   = 1'b0;
    exp_data  = '0;
    pin_chk   = 1'b0;
    exp_out   = '0;
    exp_dir   = '0;
    exp_iosel = '0;
    exp_inta  = 1'b0;
    cur_name  = "reset";
    // Reset values, every pin an input
    for (int r = 0; r < 8; r++) begin
      model[r] = '0;
    end
    model[2] = '1;
    load_table();
    limit = 40 * n_steps + 200;
    repeat (10) @(posedge wb_clk_i);
    @(negedge wb_clk_i);
    wb_rst_i = 1'b0;
    for (int k = 0; k < n_steps; k++) begin
      run_step(steps[k]);
    end
    repeat (3) @(negedge wb_clk_i);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
hdl/gpio_pkg.sv
hdl/gpio_reg_bus_if.sv
hdl/gpio_wb_slave.sv
hdl/gpio_regfile.sv
hdl/gpio_input_sync.sv
hdl/gpio_irq_ctrl.sv
hdl/gpio_top.sv
tb/gpio_checker.sv
tb/gpio_tb.sv
